// ==== include/mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define DATA_W 32
`define REG_AW 5
`define REG_N 32
`define DMEM_AW 5
`define IMM_W 16
`define TARGET_W 26

// Instruction field positions
`define OP_LSB 26
`define OP_W 6
`define RS_LSB 21
`define RT_LSB 16
`define RD_LSB 11
`define SHAMT_LSB 6
`define FUNCT_W 6

`endif

// ==== verilog/mips_pkg.sv ====
package mips_pkg;

        typedef enum logic [5:0] {
                OP_RTYPE = 6'b000000,
                OP_J     = 6'b000010,
                OP_BEQ   = 6'b000100,
                OP_BNE   = 6'b000101,
                OP_ADDI  = 6'b001000,
                OP_ANDI  = 6'b001100,
                OP_ORI   = 6'b001101,
                OP_LW    = 6'b100011,
                OP_SW    = 6'b101011
        } opcode_e;

        typedef enum logic [5:0] {
                FN_SLL = 6'b000000,
                FN_SRL = 6'b000010,
                FN_ADD = 6'b100000,
                FN_SUB = 6'b100010,
                FN_AND = 6'b100100,
                FN_OR  = 6'b100101,
                FN_XOR = 6'b100110,
                FN_NOR = 6'b100111,
                FN_SLT = 6'b101010
        } funct_e;

        typedef enum logic [3:0] {
                ALU_ADD = 4'b0000,
                ALU_SUB = 4'b0001,
                ALU_AND = 4'b0010,
                ALU_OR  = 4'b0011,
                ALU_XOR = 4'b0100,
                ALU_NOR = 4'b0110,
                ALU_SLL = 4'b1000,
                ALU_SRL = 4'b1001,
                ALU_SLT = 4'b1101
        } alu_op_e;

        typedef enum logic [1:0] {
                BR_NONE = 2'b00,
                BR_EQ   = 2'b01,
                BR_NE   = 2'b10
        } branch_cond_e;

endpackage

// ==== verilog/decode_if.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

interface decode_if;
        mips_pkg::alu_op_e      alu_op;
        logic                   alu_src_imm;    // Immediate as second operand
        logic                   shift_imm;      // Shamt as first operand
        logic                   reg_write;
        logic                   reg_dst_rd;
        logic                   mem_write;
        logic                   mem_to_reg;
        mips_pkg::branch_cond_e branch_cond;
        logic                   jump;
        logic [`REG_AW-1:0]     rs;
        logic [`REG_AW-1:0]     rt;
        logic [`REG_AW-1:0]     rd;
        logic [`REG_AW-1:0]     shamt;
        logic [`DATA_W-1:0]     imm;
        logic [`TARGET_W-1:0]   target;

        modport dec (output alu_op, alu_src_imm, shift_imm, reg_write, reg_dst_rd, mem_write,
                mem_to_reg, branch_cond, jump, rs, rt, rd, shamt, imm, target);
        modport dp (input alu_op, alu_src_imm, shift_imm, reg_write, reg_dst_rd, mem_write,
                mem_to_reg, branch_cond, jump, rs, rt, rd, shamt, imm, target);
endinterface

// ==== verilog/pc_unit.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module pc_unit (
        input  logic               clk,
        input  logic               arst_n,
        input  logic               zero,
        decode_if.dp               ctl,
        output logic [`DATA_W-1:0] pc
);

        logic               taken;
        logic [`DATA_W-1:0] pc_seq;
        logic [`DATA_W-1:0] br_target;
        logic [`DATA_W-1:0] jmp_target;
        logic [`DATA_W-1:0] pc_next;

        assign taken = (ctl.branch_cond == mips_pkg::BR_EQ && zero) ||
                       (ctl.branch_cond == mips_pkg::BR_NE && !zero);

        // pc already holds the branch address plus 4
        assign pc_seq = pc + `DATA_W'd4;
        assign br_target = pc + {{(`DATA_W-`IMM_W-2){ctl.imm[`IMM_W-1]}},
                                 ctl.imm[`IMM_W-1:0], 2'b00};
        assign jmp_target = {pc[`DATA_W-1:`TARGET_W+2], ctl.target, 2'b00};

        always_comb
        begin
                if (ctl.jump)
                        pc_next = jmp_target;
                else if (taken)
                        pc_next = br_target;
                else
                        pc_next = pc_seq;
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        pc <= '0;
                else
                        pc <= pc_next;
        end

        // The priority mux assumes jump and branch never coincide
        a_no_jump_branch: assert property (@(posedge clk) disable iff (!arst_n)
                !(ctl.jump && ctl.branch_cond != mips_pkg::BR_NONE))
                else $error("jump and branch condition both set");

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module decoder (
        input  logic [`DATA_W-1:0] instr,
        decode_if.dec              ctl
);

        mips_pkg::opcode_e opcode;
        mips_pkg::funct_e  funct;
        logic              zext_imm;

        assign opcode = mips_pkg::opcode_e'(instr[`OP_LSB +: `OP_W]);
        assign funct = mips_pkg::funct_e'(instr[`FUNCT_W-1:0]);

        assign ctl.rs = instr[`RS_LSB +: `REG_AW];
        assign ctl.rt = instr[`RT_LSB +: `REG_AW];
        assign ctl.rd = instr[`RD_LSB +: `REG_AW];
        assign ctl.shamt = instr[`SHAMT_LSB +: `REG_AW];
        assign ctl.target = instr[`TARGET_W-1:0];
        assign ctl.imm = zext_imm ? {{(`DATA_W-`IMM_W){1'b0}}, instr[`IMM_W-1:0]} :
                                    {{(`DATA_W-`IMM_W){instr[`IMM_W-1]}}, instr[`IMM_W-1:0]};

        always_comb
        begin
                ctl.alu_op = mips_pkg::ALU_ADD;
                ctl.alu_src_imm = 1'b0;
                ctl.shift_imm = 1'b0;
                ctl.reg_write = 1'b0;
                ctl.reg_dst_rd = 1'b0;
                ctl.mem_write = 1'b0;
                ctl.mem_to_reg = 1'b0;
                ctl.branch_cond = mips_pkg::BR_NONE;
                ctl.jump = 1'b0;
                zext_imm = 1'b0;
                case (opcode)
                mips_pkg::OP_RTYPE:
                begin
                        ctl.reg_write = 1'b1;
                        ctl.reg_dst_rd = 1'b1;
                        case (funct)
                        mips_pkg::FN_ADD: ctl.alu_op = mips_pkg::ALU_ADD;
                        mips_pkg::FN_SUB: ctl.alu_op = mips_pkg::ALU_SUB;
                        mips_pkg::FN_AND: ctl.alu_op = mips_pkg::ALU_AND;
                        mips_pkg::FN_OR:  ctl.alu_op = mips_pkg::ALU_OR;
                        mips_pkg::FN_XOR: ctl.alu_op = mips_pkg::ALU_XOR;
                        mips_pkg::FN_NOR: ctl.alu_op = mips_pkg::ALU_NOR;
                        mips_pkg::FN_SLT: ctl.alu_op = mips_pkg::ALU_SLT;
                        mips_pkg::FN_SLL:
                        begin
                                ctl.alu_op = mips_pkg::ALU_SLL;
                                ctl.shift_imm = 1'b1;
                        end
                        mips_pkg::FN_SRL:
                        begin
                                ctl.alu_op = mips_pkg::ALU_SRL;
                                ctl.shift_imm = 1'b1;
                        end
                        default: ctl.reg_write = 1'b0;      // Unknown funct is a no-op
                        endcase
                end
                mips_pkg::OP_ADDI, mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_LW:
                begin
                        ctl.reg_write = 1'b1;
                        ctl.alu_src_imm = 1'b1;
                        zext_imm = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI);
                        ctl.mem_to_reg = (opcode == mips_pkg::OP_LW);
                        if (opcode == mips_pkg::OP_ANDI)
                                ctl.alu_op = mips_pkg::ALU_AND;
                        else if (opcode == mips_pkg::OP_ORI)
                                ctl.alu_op = mips_pkg::ALU_OR;
                end
                mips_pkg::OP_SW:
                begin
                        ctl.mem_write = 1'b1;
                        ctl.alu_src_imm = 1'b1;
                end
                mips_pkg::OP_BEQ:
                begin
                        ctl.alu_op = mips_pkg::ALU_SUB;     // Zero flag gives equality
                        ctl.branch_cond = mips_pkg::BR_EQ;
                end
                mips_pkg::OP_BNE:
                begin
                        ctl.alu_op = mips_pkg::ALU_SUB;
                        ctl.branch_cond = mips_pkg::BR_NE;
                end
                mips_pkg::OP_J: ctl.jump = 1'b1;
                default: ;
                endcase
        end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module alu (
        input  logic [`DATA_W-1:0] a,
        input  logic [`DATA_W-1:0] b,
        input  mips_pkg::alu_op_e  op,
        output logic [`DATA_W-1:0] result,
        output logic               zero
);

        logic [`REG_AW-1:0] sh_amt;

        assign sh_amt = a[`REG_AW-1:0];     // Shift amount arrives on a

        always_comb
        begin
                case (op)
                mips_pkg::ALU_ADD: result = a + b;
                mips_pkg::ALU_SUB: result = a - b;
                mips_pkg::ALU_AND: result = a & b;
                mips_pkg::ALU_OR:  result = a | b;
                mips_pkg::ALU_XOR: result = a ^ b;
                mips_pkg::ALU_NOR: result = ~(a | b);
                mips_pkg::ALU_SLT: result = {{(`DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
                mips_pkg::ALU_SLL: result = b << sh_amt;
                mips_pkg::ALU_SRL: result = b >> sh_amt;
                default:           result = '0;
                endcase
        end

        assign zero = (result == '0);

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module reg_file (
        input  logic               clk,
        input  logic               arst_n,
        decode_if.dp               ctl,
        input  logic               wr_en,
        input  logic [`REG_AW-1:0] wr_idx,
        input  logic [`DATA_W-1:0] wr_data,
        output logic [`DATA_W-1:0] rs_data,
        output logic [`DATA_W-1:0] rt_data
);

        logic [`DATA_W-1:0] regs [`REG_N];

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        for (int i = 0; i < `REG_N; i++)
                                regs[i] <= '0;
                end
                else if (wr_en)
                begin
                        regs[wr_idx] <= wr_data;
                end
        end

        // Register 0 hardwired to zero on read
        assign rs_data = (ctl.rs == '0) ? '0 : regs[ctl.rs];
        assign rt_data = (ctl.rt == '0) ? '0 : regs[ctl.rt];

        // The core must gate writes aimed at register 0
        a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
                wr_en |-> wr_idx != '0)
                else $error("write to register 0 with data %h", wr_data);

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module data_mem (
        input  logic                clk,
        input  logic                arst_n,
        input  logic                wr_en,
        input  logic [`DMEM_AW-1:0] addr,
        input  logic [`DATA_W-1:0]  wr_data,
        output logic [`DATA_W-1:0]  rd_data
);

        logic [`DATA_W-1:0] mem [2**`DMEM_AW];

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        for (int i = 0; i < 2**`DMEM_AW; i++)
                                mem[i] <= '0;
                end
                else if (wr_en)
                begin
                        mem[addr] <= wr_data;
                end
        end

        assign rd_data = mem[addr];     // Word index, not byte address

endmodule

// ==== verilog/mips_core.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module mips_core (
        input  logic                clk,
        input  logic                arst_n,
        input  logic [`DATA_W-1:0]  imem_data,      // ROM output, instruction in execute
        output logic [`DATA_W-1:0]  imem_addr,
        output logic                reg_wr_en,
        output logic [`REG_AW-1:0]  reg_wr_idx,
        output logic [`DATA_W-1:0]  reg_wr_data,
        output logic                mem_wr_en,
        output logic [`DMEM_AW-1:0] mem_wr_addr,
        output logic [`DATA_W-1:0]  mem_wr_data
);

        decode_if ctl ();

        logic [`DATA_W-1:0] rs_data;
        logic [`DATA_W-1:0] rt_data;
        logic [`DATA_W-1:0] alu_a;
        logic [`DATA_W-1:0] alu_b;
        logic [`DATA_W-1:0] alu_result;
        logic               alu_zero;
        logic [`DATA_W-1:0] load_data;

        decoder u_decoder (.instr(imem_data), .ctl(ctl.dec));

        pc_unit u_pc_unit (.clk(clk), .arst_n(arst_n), .zero(alu_zero), .ctl(ctl.dp),
                .pc(imem_addr));

        reg_file u_reg_file (.clk(clk), .arst_n(arst_n), .ctl(ctl.dp), .wr_en(reg_wr_en),
                .wr_idx(reg_wr_idx), .wr_data(reg_wr_data), .rs_data(rs_data),
                .rt_data(rt_data));

        assign alu_a = ctl.shift_imm ? {{(`DATA_W-`REG_AW){1'b0}}, ctl.shamt} : rs_data;
        assign alu_b = ctl.alu_src_imm ? ctl.imm : rt_data;

        alu u_alu (.a(alu_a), .b(alu_b), .op(ctl.alu_op), .result(alu_result), .zero(alu_zero));

        data_mem u_data_mem (.clk(clk), .arst_n(arst_n), .wr_en(mem_wr_en), .addr(mem_wr_addr),
                .wr_data(mem_wr_data), .rd_data(load_data));

        assign reg_wr_idx = ctl.reg_dst_rd ? ctl.rd : ctl.rt;
        assign reg_wr_en = ctl.reg_write && (reg_wr_idx != '0);    // Drop writes to r0
        assign reg_wr_data = ctl.mem_to_reg ? load_data : alu_result;

        assign mem_wr_en = ctl.mem_write;
        assign mem_wr_addr = alu_result[`DMEM_AW-1:0];
        assign mem_wr_data = rt_data;

endmodule

// ==== verification/tb_encode.svh ====
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

function automatic logic [31:0] r_type(input mips_pkg::funct_e fn, input logic [4:0] rd,
        input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
        return {mips_pkg::OP_RTYPE, rs, rt, rd, shamt, fn};
endfunction

function automatic logic [31:0] i_type(input mips_pkg::opcode_e op, input logic [4:0] rt,
        input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
endfunction

// Target is a word index
function automatic logic [31:0] j_type(input logic [25:0] target);
        return {mips_pkg::OP_J, target};
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
endfunction

`endif

// ==== verification/tb_mips_core.sv ====
`timescale 1ns/1ns
`include "mips_macros.svh"

module tb_mips_core;

        localparam int N_CYC = 40;              // Checked cycles after reset
        localparam int N_TESTS = 6;
        localparam int MAX_CYCLES = 200;        // Reset plus program steps with margin

        logic                clk;
        logic                arst_n;
        logic [`DATA_W-1:0]  imem_data;
        logic [`DATA_W-1:0]  imem_addr;
        logic                reg_wr_en;
        logic [`REG_AW-1:0]  reg_wr_idx;
        logic [`DATA_W-1:0]  reg_wr_data;
        logic                mem_wr_en;
        logic [`DMEM_AW-1:0] mem_wr_addr;
        logic [`DATA_W-1:0]  mem_wr_data;

        logic [`DATA_W-1:0]  prog [64];
        int                  prog_tid [64];
        int                  n_prog;
        logic [31:0]         rng;
        logic [`DATA_W-1:0]  exp_pc [N_CYC];
        logic                exp_rwe [N_CYC];
        logic [`REG_AW-1:0]  exp_ridx [N_CYC];
        logic [`DATA_W-1:0]  exp_rdata [N_CYC];
        logic                exp_mwe [N_CYC];
        logic [`DMEM_AW-1:0] exp_maddr [N_CYC];
        logic [`DATA_W-1:0]  exp_mdata [N_CYC];
        int                  exp_tid [N_CYC];  // Test owning each cycle
        int                  test_end [N_TESTS];
        int                  fails [N_TESTS];
        string               test_name [N_TESTS];
        int                  cyc;
        int                  rst_cyc;
        int                  total_cyc;
        int                  errors;
        int                  passed;

        `include "tb_encode.svh"

        mips_core dut (.clk(clk), .arst_n(arst_n), .imem_data(imem_data), .imem_addr(imem_addr),
                .reg_wr_en(reg_wr_en), .reg_wr_idx(reg_wr_idx), .reg_wr_data(reg_wr_data),
                .mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data));

        initial clk = 1'b0;
        always #20 clk = ~clk;

        function automatic logic [31:0] rand_word();
                rng = xorshift32(rng);
                return rng;
        endfunction

        task automatic emit(input logic [31:0] w, input int tid);
                prog[n_prog] = w;
                prog_tid[n_prog] = tid;
                n_prog++;
        endtask

        task automatic record_failure(input int tid, input string msg);
                $display("[FAIL] %0t: %s", $time, msg);
                fails[tid]++;
                errors++;
        endtask

        task automatic build_program();
                logic [31:0] r;
                logic [15:0] v1;
                logic [15:0] v2;
                logic [15:0] a1;
                logic [15:0] a2;
                n_prog = 0;
                for (int i = 0; i < 64; i++)
                begin
                        prog[i] = '0;
                        prog_tid[i] = 5;
                end
                r = rand_word();
                v1 = r[15:0];
                r = rand_word();
                v2 = r[15:0];
                if (v2 == v1)
                        v2 = ~v1;       // Keeps r1 and r2 apart for the branches
                emit(i_type(mips_pkg::OP_ADDI, 5'd1, 5'd0, v1), 1);
                emit(i_type(mips_pkg::OP_ADDI, 5'd2, 5'd0, v2), 1);
                r = rand_word();
                emit(i_type(mips_pkg::OP_ADDI, 5'd3, 5'd0, r[15:0] | 16'h8000), 1);
                emit(r_type(mips_pkg::FN_ADD, 5'd4, 5'd1, 5'd2, 5'd0), 1);
                emit(r_type(mips_pkg::FN_SUB, 5'd5, 5'd1, 5'd2, 5'd0), 1);
                emit(r_type(mips_pkg::FN_AND, 5'd6, 5'd1, 5'd3, 5'd0), 1);
                emit(r_type(mips_pkg::FN_OR, 5'd7, 5'd2, 5'd3, 5'd0), 1);
                emit(r_type(mips_pkg::FN_XOR, 5'd8, 5'd1, 5'd3, 5'd0), 1);
                emit(r_type(mips_pkg::FN_NOR, 5'd9, 5'd2, 5'd3, 5'd0), 1);
                emit(r_type(mips_pkg::FN_SLT, 5'd10, 5'd1, 5'd2, 5'd0), 1);
                emit(r_type(mips_pkg::FN_SLT, 5'd11, 5'd2, 5'd1, 5'd0), 1);
                r = rand_word();
                emit(i_type(mips_pkg::OP_ANDI, 5'd12, 5'd3, r[15:0] | 16'h8000), 1);
                r = rand_word();
                // Source r12 keeps its upper half zero
                emit(i_type(mips_pkg::OP_ORI, 5'd13, 5'd12, r[15:0] | 16'h8000), 1);
                r = rand_word();
                emit(r_type(mips_pkg::FN_SLL, 5'd14, 5'd0, 5'd1, r[4:0]), 2);
                r = rand_word();
                emit(r_type(mips_pkg::FN_SRL, 5'd15, 5'd0, 5'd3, r[4:0] | 5'd1), 2);
                r = rand_word();
                a1 = {11'd0, r[4:0]};
                a2 = {11'd0, r[4:0] + 5'd1 + {1'b0, r[8:5]}};       // Never equal to a1
                emit(i_type(mips_pkg::OP_SW, 5'd4, 5'd0, a1), 3);
                emit(i_type(mips_pkg::OP_SW, 5'd5, 5'd0, a2), 3);
                emit(i_type(mips_pkg::OP_LW, 5'd16, 5'd0, a1), 3);
                emit(i_type(mips_pkg::OP_LW, 5'd17, 5'd0, a2), 3);
                emit(i_type(mips_pkg::OP_BEQ, 5'd1, 5'd1, 16'd2), 4);     // Taken
                emit(i_type(mips_pkg::OP_ADDI, 5'd18, 5'd0, 16'd1), 4);
                emit(i_type(mips_pkg::OP_ADDI, 5'd19, 5'd0, 16'h77), 4);  // Skipped
                emit(i_type(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'd2), 4);     // Not taken
                emit(i_type(mips_pkg::OP_ADDI, 5'd19, 5'd0, 16'd5), 4);
                emit(i_type(mips_pkg::OP_ADDI, 5'd20, 5'd0, 16'd6), 4);
                emit(i_type(mips_pkg::OP_BNE, 5'd2, 5'd1, 16'd2), 4);     // Taken
                emit(i_type(mips_pkg::OP_ADDI, 5'd21, 5'd0, 16'd7), 4);
                emit(i_type(mips_pkg::OP_ADDI, 5'd22, 5'd0, 16'd8), 4);
                emit(j_type(26'(n_prog + 3)), 4);
                emit(i_type(mips_pkg::OP_ADDI, 5'd23, 5'd0, 16'd9), 4);
                emit(i_type(mips_pkg::OP_ADDI, 5'd24, 5'd0, 16'd10), 4);
                emit(r_type(mips_pkg::FN_ADD, 5'd0, 5'd1, 5'd2, 5'd0), 5);
                emit(r_type(mips_pkg::FN_ADD, 5'd25, 5'd0, 5'd0, 5'd0), 5);
                emit(r_type(mips_pkg::FN_OR, 5'd26, 5'd0, 5'd1, 5'd0), 5);
                emit(j_type(26'(n_prog)), 5);   // Halt loop
                emit(32'h0, 5);
        endtask

        // Issue-order model with one delay slot after each redirect
        task automatic predict();
                logic [31:0] m_reg [32];
                logic [31:0] m_mem [32];
                logic [31:0] fa;
                logic [31:0] nxt;
                logic [31:0] ex_addr;
                logic [31:0] w;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] se;
                logic [31:0] val;
                logic [31:0] addr;
                logic        ex_valid;
                logic        wr;
                logic [4:0]  idx;
                for (int i = 0; i < 32; i++)
                begin
                        m_reg[i] = '0;
                        m_mem[i] = '0;
                end
                fa = '0;
                ex_addr = '0;
                ex_valid = 1'b0;        // Cycle 0 executes the reset no-op
                for (int c = 0; c < N_CYC; c++)
                begin
                        exp_pc[c] = fa;
                        exp_rwe[c] = 1'b0;
                        exp_ridx[c] = '0;
                        exp_rdata[c] = '0;
                        exp_mwe[c] = 1'b0;
                        exp_maddr[c] = '0;
                        exp_mdata[c] = '0;
                        exp_tid[c] = ex_valid ? prog_tid[ex_addr[7:2]] : 0;
                        nxt = fa + 32'd4;
                        if (ex_valid)
                        begin
                                w = prog[ex_addr[7:2]];
                                a = m_reg[w[25:21]];
                                b = m_reg[w[20:16]];
                                se = {{16{w[15]}}, w[15:0]};
                                addr = a + se;
                                wr = 1'b1;
                                idx = w[20:16];
                                val = '0;
                                case (w[31:26])
                                mips_pkg::OP_RTYPE:
                                begin
                                        idx = w[15:11];
                                        case (w[5:0])
                                        mips_pkg::FN_ADD: val = a + b;
                                        mips_pkg::FN_SUB: val = a - b;
                                        mips_pkg::FN_AND: val = a & b;
                                        mips_pkg::FN_OR:  val = a | b;
                                        mips_pkg::FN_XOR: val = a ^ b;
                                        mips_pkg::FN_NOR: val = ~(a | b);
                                        mips_pkg::FN_SLT: val = {31'd0, $signed(a) < $signed(b)};
                                        mips_pkg::FN_SLL: val = b << w[10:6];
                                        mips_pkg::FN_SRL: val = b >> w[10:6];
                                        default:          wr = 1'b0;
                                        endcase
                                end
                                mips_pkg::OP_ADDI: val = a + se;
                                mips_pkg::OP_ANDI: val = a & {16'h0, w[15:0]};
                                mips_pkg::OP_ORI:  val = a | {16'h0, w[15:0]};
                                mips_pkg::OP_LW:   val = m_mem[addr[4:0]];
                                default:           wr = 1'b0;
                                endcase
                                if (w[31:26] == mips_pkg::OP_SW)
                                begin
                                        exp_mwe[c] = 1'b1;
                                        exp_maddr[c] = addr[4:0];
                                        exp_mdata[c] = b;
                                        m_mem[addr[4:0]] = b;
                                end
                                if ((w[31:26] == mips_pkg::OP_BEQ && a == b) ||
                                    (w[31:26] == mips_pkg::OP_BNE && a != b))
                                        nxt = ex_addr + 32'd4 + (se << 2);
                                if (w[31:26] == mips_pkg::OP_J)
                                        nxt = {fa[31:28], w[25:0], 2'b00};
                                if (wr && idx != 5'd0)
                                begin
                                        exp_rwe[c] = 1'b1;
                                        exp_ridx[c] = idx;
                                        exp_rdata[c] = val;
                                        m_reg[idx] = val;
                                end
                        end
                        ex_addr = fa;
                        ex_valid = 1'b1;
                        fa = nxt;
                end
                for (int c = 0; c < N_CYC; c++)
                        test_end[exp_tid[c]] = c;
        endtask

        initial
        begin
                arst_n = 1'b0;
                imem_data = '0;
                cyc = 0;
                rst_cyc = 0;
                total_cyc = 0;
                errors = 0;
                for (int t = 0; t < N_TESTS; t++)
                begin
                        fails[t] = 0;
                        test_end[t] = 0;
                end
                test_name[0] = "reset";
                test_name[1] = "arithmetic and logic";
                test_name[2] = "shifts";
                test_name[3] = "store and load";
                test_name[4] = "control flow";
                test_name[5] = "register 0";
                rng = 32'd83742;
                build_program();
                predict();
                repeat (10) @(posedge clk);
                arst_n <= 1'b1;
        end

        // ROM output register doubles as the execute stage
        always @(posedge clk)
        begin
                if (!arst_n)
                        imem_data <= '0;
                else
                        imem_data <= prog[imem_addr[7:2]];
        end

        a_reset_quiet: assert property (@(posedge clk)
                ((!arst_n && rst_cyc > 0) || (arst_n && cyc == 0)) |->
                (!reg_wr_en && !mem_wr_en && imem_addr == '0))
                else record_failure(0, $sformatf("outputs active in reset, addr %h",
                        $sampled(imem_addr)));

        a_fetch: assert property (@(posedge clk) (arst_n && cyc < N_CYC) |->
                imem_addr == exp_pc[cyc])
                else record_failure(exp_tid[$sampled(cyc)], $sformatf(
                        "cycle %0d fetch %h, expected %h", $sampled(cyc),
                        $sampled(imem_addr), exp_pc[$sampled(cyc)]));

        a_reg_en: assert property (@(posedge clk) (arst_n && cyc < N_CYC) |->
                reg_wr_en == exp_rwe[cyc])
                else record_failure(exp_tid[$sampled(cyc)], $sformatf(
                        "cycle %0d reg_wr_en %b, expected %b", $sampled(cyc),
                        $sampled(reg_wr_en), exp_rwe[$sampled(cyc)]));

        a_reg_data: assert property (@(posedge clk) (arst_n && cyc < N_CYC && exp_rwe[cyc]) |->
                (reg_wr_idx == exp_ridx[cyc] && reg_wr_data == exp_rdata[cyc]))
                else record_failure(exp_tid[$sampled(cyc)], $sformatf(
                        "cycle %0d write r%0d=%h, expected r%0d=%h", $sampled(cyc),
                        $sampled(reg_wr_idx), $sampled(reg_wr_data),
                        exp_ridx[$sampled(cyc)], exp_rdata[$sampled(cyc)]));

        a_mem_en: assert property (@(posedge clk) (arst_n && cyc < N_CYC) |->
                mem_wr_en == exp_mwe[cyc])
                else record_failure(exp_tid[$sampled(cyc)], $sformatf(
                        "cycle %0d mem_wr_en %b, expected %b", $sampled(cyc),
                        $sampled(mem_wr_en), exp_mwe[$sampled(cyc)]));

        a_mem_data: assert property (@(posedge clk) (arst_n && cyc < N_CYC && exp_mwe[cyc]) |->
                (mem_wr_addr == exp_maddr[cyc] && mem_wr_data == exp_mdata[cyc]))
                else record_failure(exp_tid[$sampled(cyc)], $sformatf(
                        "cycle %0d store [%0d]=%h, expected [%0d]=%h", $sampled(cyc),
                        $sampled(mem_wr_addr), $sampled(mem_wr_data),
                        exp_maddr[$sampled(cyc)], exp_mdata[$sampled(cyc)]));

        always @(posedge clk)
        begin
                total_cyc <= total_cyc + 1;
                if (!arst_n)
                        rst_cyc <= rst_cyc + 1;
                else
                        cyc <= cyc + 1;
                for (int t = 0; t < N_TESTS; t++)
                begin
                        if (arst_n && cyc == test_end[t] + 1)
                                $display("Test %0d (%s): %s, %0d errors", t, test_name[t],
                                        (fails[t] == 0) ? "passed" : "failed", fails[t]);
                end
                if (arst_n && cyc == N_CYC + 1)
                begin
                        passed = 0;
                        for (int t = 0; t < N_TESTS; t++)
                                passed += (fails[t] == 0);
                        $display("Summary: %0d of %0d tests passed, %0d check errors",
                                passed, N_TESTS, errors);
                        if (errors == 0)
                                $display("Everything OK");
                        else
                                $display("Something failed");
                        $finish;
                end
                else if (total_cyc == MAX_CYCLES)
                begin
                        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
                        $display("Something failed");
                        $finish;
                end
        end

endmodule

// ==== list.f ====
+incdir+include
+incdir+verification
verilog/mips_pkg.sv
verilog/decode_if.sv
verilog/pc_unit.sv
verilog/decoder.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/data_mem.sv
verilog/mips_core.sv
verification/tb_mips_core.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - include_dirs:
      - include
    files:
      - verilog/mips_pkg.sv
      - verilog/decode_if.sv
      - verilog/pc_unit.sv
      - verilog/decoder.sv
      - verilog/alu.sv
      - verilog/reg_file.sv
      - verilog/data_mem.sv
      - verilog/mips_core.sv
  - target: test
    include_dirs:
      - include
      - verification
    files:
      - verification/tb_mips_core.sv
